// File: hw/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    localparam int XLEN = 32;

    typedef logic [4:0] reg_addr_t;
    typedef logic [XLEN-1:0] xword_t;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcode_e;

    // alu funct3 shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    // branch funct3
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [2:0] F3_BLT = 3'b100;
    localparam logic [2:0] F3_BGE = 3'b101;

    localparam logic [6:0] FUNCT7_SUB = 7'b0100000;

    // addi x0, x0, 0
    localparam xword_t INST_NOP = 32'h0000_0013;

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef struct packed {
        logic [19:0] imm31_12;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        b_fmt_t b_fmt;
        j_fmt_t j_fmt;
        u_fmt_t u_fmt;
    } inst_u;

endpackage

`default_nettype wire

// File: hw/core_pipe_pkg.sv
`default_nettype none

package core_pipe_pkg;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS2
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE
    } br_op_e;

    typedef enum logic {
        OP2_RS2,
        OP2_IMM
    } op2_sel_e;

    typedef struct packed {
        alu_op_e               alu_op;
        br_op_e                br_op;
        op2_sel_e              op2_sel;
        logic                  jal;
        logic                  use_rs1;
        logic                  use_rs2;
        logic                  rf_wen;
        rv_isa_pkg::reg_addr_t rd;
        rv_isa_pkg::reg_addr_t rs1;
        rv_isa_pkg::reg_addr_t rs2;
    } ctrl_t;

    typedef struct packed {
        logic               valid;
        rv_isa_pkg::xword_t pc;
        rv_isa_pkg::xword_t inst;
    } fetch_resp_t;

    typedef struct packed {
        logic               valid;
        rv_isa_pkg::xword_t target;
    } redirect_t;

    // decode to operand select
    typedef struct packed {
        logic               valid;
        rv_isa_pkg::xword_t pc;
        ctrl_t              ctrl;
        rv_isa_pkg::xword_t imm;
    } decoded_t;

    // operand select to execute
    typedef struct packed {
        logic               valid;
        rv_isa_pkg::xword_t pc;
        ctrl_t              ctrl;
        rv_isa_pkg::xword_t op1;
        rv_isa_pkg::xword_t op2;
        rv_isa_pkg::xword_t rs2_data;
        rv_isa_pkg::xword_t imm;
    } exec_in_t;

    typedef struct packed {
        logic                  valid;
        rv_isa_pkg::xword_t    pc;
        rv_isa_pkg::reg_addr_t rd;
        logic                  rf_wen;
        rv_isa_pkg::xword_t    result;
    } wb_in_t;

    typedef struct packed {
        logic                  valid;
        rv_isa_pkg::reg_addr_t addr;
        rv_isa_pkg::xword_t    data;
    } fw_t;

    typedef struct packed {
        logic                  valid;
        rv_isa_pkg::xword_t    pc;
        logic                  rf_wen;
        rv_isa_pkg::reg_addr_t rd;
        rv_isa_pkg::xword_t    wdata;
    } retire_t;

endpackage

`default_nettype wire

// File: hw/inst_decode.sv
`default_nettype none
`timescale 1ns/1ps

module inst_decode (
    input  wire                         clk,
    input  wire                         rst_i,
    input  wire core_pipe_pkg::fetch_resp_t fetch_resp_i,
    input  wire                         ds_stall_i,
    input  wire                         exe_stall_i,
    input  wire                         flush_i,
    input  wire core_pipe_pkg::redirect_t   redirect_i,
    output logic                        fetch_ready_o,
    output core_pipe_pkg::decoded_t     dec_o
);

    core_pipe_pkg::fetch_resp_t id_q;
    logic                       run_q;
    logic                       id_stall;
    rv_isa_pkg::inst_u          word;
    rv_isa_pkg::opcode_e        opc;
    logic                       is_op;
    core_pipe_pkg::ctrl_t       ctrl;
    rv_isa_pkg::xword_t         imm;

    assign id_stall = id_q.valid && (ds_stall_i || exe_stall_i);
    // closed until the first redirect after reset
    assign fetch_ready_o = run_q && !id_stall;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            run_q      <= 1'b0;
            id_q.valid <= 1'b0;
        end else begin
            if (redirect_i.valid) begin
                run_q <= 1'b1;
            end
            if (flush_i || redirect_i.valid) begin
                id_q.valid <= 1'b0;
            end else if (!id_stall) begin
                id_q.valid <= fetch_resp_i.valid && run_q;
                id_q.pc    <= fetch_resp_i.pc;
                id_q.inst  <= fetch_resp_i.inst;
            end
        end
    end

    // empty slot decodes as a nop
    assign word  = id_q.valid ? id_q.inst : rv_isa_pkg::INST_NOP;
    assign opc   = rv_isa_pkg::opcode_e'(word.r_fmt.opcode);
    assign is_op = (opc == rv_isa_pkg::OP);

    always_comb begin
        ctrl     = '0;
        ctrl.rd  = word.r_fmt.rd;
        ctrl.rs1 = word.r_fmt.rs1;
        ctrl.rs2 = word.r_fmt.rs2;
        imm      = '0;
        case (opc)
            rv_isa_pkg::OP, rv_isa_pkg::OP_IMM: begin
                ctrl.use_rs1 = 1'b1;
                ctrl.use_rs2 = is_op;
                ctrl.rf_wen  = 1'b1;
                if (!is_op) begin
                    ctrl.op2_sel = core_pipe_pkg::OP2_IMM;
                end
                imm = {{20{word.i_fmt.imm[11]}}, word.i_fmt.imm};
                case (word.r_fmt.funct3)
                    rv_isa_pkg::F3_ADD: begin
                        if (is_op && word.r_fmt.funct7 == rv_isa_pkg::FUNCT7_SUB) begin
                            ctrl.alu_op = core_pipe_pkg::ALU_SUB;
                        end else begin
                            ctrl.alu_op = core_pipe_pkg::ALU_ADD;
                        end
                    end
                    rv_isa_pkg::F3_SLT: ctrl.alu_op = core_pipe_pkg::ALU_SLT;
                    rv_isa_pkg::F3_XOR: ctrl.alu_op = core_pipe_pkg::ALU_XOR;
                    rv_isa_pkg::F3_OR:  ctrl.alu_op = core_pipe_pkg::ALU_OR;
                    rv_isa_pkg::F3_AND: ctrl.alu_op = core_pipe_pkg::ALU_AND;
                    default:            ctrl = '0;
                endcase
            end
            rv_isa_pkg::LUI: begin
                ctrl.rf_wen  = 1'b1;
                ctrl.op2_sel = core_pipe_pkg::OP2_IMM;
                ctrl.alu_op  = core_pipe_pkg::ALU_PASS2;
                imm          = {word.u_fmt.imm31_12, 12'h000};
            end
            rv_isa_pkg::BRANCH: begin
                ctrl.use_rs1 = 1'b1;
                ctrl.use_rs2 = 1'b1;
                imm = {{20{word.b_fmt.imm12}}, word.b_fmt.imm11, word.b_fmt.imm10_5,
                       word.b_fmt.imm4_1, 1'b0};
                case (word.r_fmt.funct3)
                    rv_isa_pkg::F3_BEQ: ctrl.br_op = core_pipe_pkg::BR_EQ;
                    rv_isa_pkg::F3_BNE: ctrl.br_op = core_pipe_pkg::BR_NE;
                    rv_isa_pkg::F3_BLT: ctrl.br_op = core_pipe_pkg::BR_LT;
                    rv_isa_pkg::F3_BGE: ctrl.br_op = core_pipe_pkg::BR_GE;
                    default:            ctrl = '0;
                endcase
            end
            rv_isa_pkg::JAL: begin
                ctrl.rf_wen = 1'b1;
                ctrl.jal    = 1'b1;
                imm = {{12{word.j_fmt.imm20}}, word.j_fmt.imm19_12, word.j_fmt.imm11,
                       word.j_fmt.imm10_1, 1'b0};
            end
            default: ctrl = '0;
        endcase
        // x0 never takes a write
        if (ctrl.rd == '0) begin
            ctrl.rf_wen = 1'b0;
        end
    end

    assign dec_o.valid = id_q.valid;
    assign dec_o.pc    = id_q.pc;
    assign dec_o.ctrl  = ctrl;
    assign dec_o.imm   = imm;

endmodule

`default_nettype wire

// File: hw/operand_stage.sv
`default_nettype none
`timescale 1ns/1ps

module operand_stage (
    input  wire                           clk,
    input  wire                           rst_i,
    input  wire core_pipe_pkg::decoded_t  dec_i,
    input  wire core_pipe_pkg::fw_t       exe_fw_i,
    input  wire core_pipe_pkg::fw_t       wb_fw_i,
    input  wire rv_isa_pkg::xword_t       rf_rdata1_i,
    input  wire rv_isa_pkg::xword_t       rf_rdata2_i,
    input  wire                           exe_stall_i,
    input  wire                           flush_i,
    output rv_isa_pkg::reg_addr_t         rf_raddr1_o,
    output rv_isa_pkg::reg_addr_t         rf_raddr2_o,
    output logic                          ds_stall_o,
    output core_pipe_pkg::exec_in_t       exec_o
);

    core_pipe_pkg::decoded_t ds_q;
    rv_isa_pkg::xword_t      rs1_val;
    rv_isa_pkg::xword_t      rs2_val;
    logic                    rs1_hit;
    logic                    rs2_hit;

    function automatic rv_isa_pkg::xword_t fwd_pick(
        input rv_isa_pkg::reg_addr_t addr,
        input rv_isa_pkg::xword_t    rf_data,
        input core_pipe_pkg::fw_t    src
    );
        if (src.valid && addr != '0 && addr == src.addr) begin
            return src.data;
        end
        return rf_data;
    endfunction

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ds_q.valid <= 1'b0;
        end else if (flush_i) begin
            ds_q.valid <= 1'b0;
        end else if (!ds_stall_o && !exe_stall_i) begin
            ds_q <= dec_i;
        end
    end

    assign rf_raddr1_o = ds_q.ctrl.rs1;
    assign rf_raddr2_o = ds_q.ctrl.rs2;

    // the value being written back is newer than the register file
    assign rs1_val = fwd_pick(ds_q.ctrl.rs1, rf_rdata1_i, wb_fw_i);
    assign rs2_val = fwd_pick(ds_q.ctrl.rs2, rf_rdata2_i, wb_fw_i);

    // no forwarding out of execute so the stage waits a cycle
    assign rs1_hit    = ds_q.ctrl.use_rs1 && ds_q.ctrl.rs1 == exe_fw_i.addr;
    assign rs2_hit    = ds_q.ctrl.use_rs2 && ds_q.ctrl.rs2 == exe_fw_i.addr;
    assign ds_stall_o = ds_q.valid && exe_fw_i.valid && exe_fw_i.addr != '0 &&
                        (rs1_hit || rs2_hit);

    assign exec_o.valid    = ds_q.valid;
    assign exec_o.pc       = ds_q.pc;
    assign exec_o.ctrl     = ds_q.ctrl;
    assign exec_o.op1      = rs1_val;
    assign exec_o.op2      = (ds_q.ctrl.op2_sel == core_pipe_pkg::OP2_IMM) ? ds_q.imm : rs2_val;
    assign exec_o.rs2_data = rs2_val;
    assign exec_o.imm      = ds_q.imm;

    // execute takes a bubble behind the producer and the hazard lasts one cycle
    assert property (@(posedge clk) disable iff (rst_i)
        ds_stall_o |=> !ds_stall_o);

endmodule

`default_nettype wire

// File: hw/execute_stage.sv
`default_nettype none
`timescale 1ns/1ps

module execute_stage #(
    parameter rv_isa_pkg::xword_t RESET_PC = 32'h0000_0000
) (
    input  wire                           clk,
    input  wire                           rst_i,
    input  wire core_pipe_pkg::exec_in_t  exec_i,
    input  wire                           ds_stall_i,
    input  wire rv_isa_pkg::xword_t       succ_pc_i,
    input  wire                           succ_valid_i,
    output logic                          exe_stall_o,
    output logic                          flush_o,
    output core_pipe_pkg::redirect_t      redirect_o,
    output core_pipe_pkg::fw_t            exe_fw_o,
    output core_pipe_pkg::wb_in_t         wb_o
);

    core_pipe_pkg::exec_in_t  exe_q;
    core_pipe_pkg::redirect_t redirect_q;
    logic                     boot_q;
    rv_isa_pkg::xword_t       alu_out;
    rv_isa_pkg::xword_t       seq_pc;
    rv_isa_pkg::xword_t       target;
    rv_isa_pkg::xword_t       next_pc;
    rv_isa_pkg::xword_t       result;
    logic                     is_cf;
    logic                     eq;
    logic                     lt;
    logic                     taken;

    always_comb begin
        case (exe_q.ctrl.alu_op)
            core_pipe_pkg::ALU_ADD:   alu_out = exe_q.op1 + exe_q.op2;
            core_pipe_pkg::ALU_SUB:   alu_out = exe_q.op1 - exe_q.op2;
            core_pipe_pkg::ALU_AND:   alu_out = exe_q.op1 & exe_q.op2;
            core_pipe_pkg::ALU_OR:    alu_out = exe_q.op1 | exe_q.op2;
            core_pipe_pkg::ALU_XOR:   alu_out = exe_q.op1 ^ exe_q.op2;
            core_pipe_pkg::ALU_SLT:   alu_out = {31'b0, $signed(exe_q.op1) < $signed(exe_q.op2)};
            core_pipe_pkg::ALU_PASS2: alu_out = exe_q.op2;
            default:                  alu_out = '0;
        endcase
    end

    assign eq = (exe_q.op1 == exe_q.rs2_data);
    assign lt = ($signed(exe_q.op1) < $signed(exe_q.rs2_data));

    always_comb begin
        case (exe_q.ctrl.br_op)
            core_pipe_pkg::BR_EQ: taken = eq;
            core_pipe_pkg::BR_NE: taken = !eq;
            core_pipe_pkg::BR_LT: taken = lt;
            core_pipe_pkg::BR_GE: taken = !lt;
            default:              taken = exe_q.ctrl.jal;
        endcase
    end

    assign seq_pc  = exe_q.pc + 32'd4;
    assign target  = exe_q.pc + exe_q.imm;
    assign next_pc = taken ? target : seq_pc;
    assign result  = exe_q.ctrl.jal ? seq_pc : alu_out;

    // fetch is sequential, so only control flow needs a look at its successor
    assign is_cf       = (exe_q.ctrl.br_op != core_pipe_pkg::BR_NONE) || exe_q.ctrl.jal;
    assign exe_stall_o = exe_q.valid && is_cf && !succ_valid_i;
    assign flush_o     = exe_q.valid && is_cf && succ_valid_i && (succ_pc_i != next_pc);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            exe_q.valid <= 1'b0;
        end else if (!exe_stall_o) begin
            if (flush_o || ds_stall_i) begin
                exe_q.valid <= 1'b0;
            end else begin
                exe_q <= exec_i;
            end
        end
    end

    // boot pulse restarts fetch at RESET_PC
    always_ff @(posedge clk) begin
        if (rst_i) begin
            boot_q           <= 1'b1;
            redirect_q.valid <= 1'b0;
        end else begin
            boot_q            <= 1'b0;
            redirect_q.valid  <= boot_q || flush_o;
            redirect_q.target <= boot_q ? RESET_PC : next_pc;
        end
    end

    assign redirect_o = redirect_q;

    assign exe_fw_o.valid = exe_q.valid && exe_q.ctrl.rf_wen;
    assign exe_fw_o.addr  = exe_q.ctrl.rd;
    assign exe_fw_o.data  = result;

    // a held branch must not retire more than once
    assign wb_o.valid  = exe_q.valid && !exe_stall_o;
    assign wb_o.pc     = exe_q.pc;
    assign wb_o.rd     = exe_q.ctrl.rd;
    assign wb_o.rf_wen = exe_q.ctrl.rf_wen;
    assign wb_o.result = result;

    assert property (@(posedge clk) disable iff (rst_i)
        redirect_o.valid |=> !redirect_o.valid);

    // wrong-path work in the operand stage is dropped behind a misprediction
    assert property (@(posedge clk) disable iff (rst_i)
        flush_o |=> !exec_i.valid);

endmodule

`default_nettype wire

// File: hw/writeback_regfile.sv
`default_nettype none
`timescale 1ns/1ps

module writeback_regfile (
    input  wire                         clk,
    input  wire                         rst_i,
    input  wire core_pipe_pkg::wb_in_t  wb_i,
    input  wire rv_isa_pkg::reg_addr_t  rf_raddr1_i,
    input  wire rv_isa_pkg::reg_addr_t  rf_raddr2_i,
    output rv_isa_pkg::xword_t          rf_rdata1_o,
    output rv_isa_pkg::xword_t          rf_rdata2_o,
    output core_pipe_pkg::fw_t          wb_fw_o,
    output core_pipe_pkg::retire_t      retire_o
);

    core_pipe_pkg::wb_in_t wb_q;
    rv_isa_pkg::xword_t    regs [1:31];
    logic                  we;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wb_q.valid <= 1'b0;
        end else begin
            wb_q <= wb_i;
        end
    end

    assign we = wb_q.valid && wb_q.rf_wen && wb_q.rd != '0;

    always_ff @(posedge clk) begin
        if (we) begin
            regs[wb_q.rd] <= wb_q.result;
        end
    end

    // x0 is hardwired
    assign rf_rdata1_o = (rf_raddr1_i == '0) ? '0 : regs[rf_raddr1_i];
    assign rf_rdata2_o = (rf_raddr2_i == '0) ? '0 : regs[rf_raddr2_i];

    assign wb_fw_o.valid = wb_q.valid && wb_q.rf_wen;
    assign wb_fw_o.addr  = wb_q.rd;
    assign wb_fw_o.data  = wb_q.result;

    assign retire_o.valid  = wb_q.valid;
    assign retire_o.pc     = wb_q.pc;
    assign retire_o.rf_wen = wb_q.rf_wen;
    assign retire_o.rd     = wb_q.rd;
    assign retire_o.wdata  = wb_q.result;

    // decode drops rf_wen for rd x0
    assert property (@(posedge clk) disable iff (rst_i)
        wb_q.valid && wb_q.rf_wen |-> wb_q.rd != '0);

endmodule

`default_nettype wire

// File: hw/rv_core_top.sv
`default_nettype none
`timescale 1ns/1ps

module rv_core_top #(
    parameter rv_isa_pkg::xword_t RESET_PC = 32'h0000_0000
) (
    input  wire                             clk,
    input  wire                             rst_i,
    input  wire core_pipe_pkg::fetch_resp_t fetch_resp_i,
    output logic                            fetch_ready_o,
    output core_pipe_pkg::redirect_t        redirect_o,
    output core_pipe_pkg::retire_t          retire_o
);

    core_pipe_pkg::decoded_t dec;
    core_pipe_pkg::exec_in_t exec;
    core_pipe_pkg::wb_in_t   wb;
    core_pipe_pkg::fw_t      exe_fw;
    core_pipe_pkg::fw_t      wb_fw;
    rv_isa_pkg::reg_addr_t   rf_raddr1;
    rv_isa_pkg::reg_addr_t   rf_raddr2;
    rv_isa_pkg::xword_t      rf_rdata1;
    rv_isa_pkg::xword_t      rf_rdata2;
    rv_isa_pkg::xword_t      succ_pc;
    logic                    succ_valid;
    logic                    ds_stall;
    logic                    exe_stall;
    logic                    flush;

    // oldest younger instruction, DS before ID
    assign succ_valid = exec.valid || dec.valid;
    assign succ_pc    = exec.valid ? exec.pc : dec.pc;

    inst_decode u_decode (
        .clk           (clk),
        .rst_i         (rst_i),
        .fetch_resp_i  (fetch_resp_i),
        .ds_stall_i    (ds_stall),
        .exe_stall_i   (exe_stall),
        .flush_i       (flush),
        .redirect_i    (redirect_o),
        .fetch_ready_o (fetch_ready_o),
        .dec_o         (dec)
    );

    operand_stage u_operand (
        .clk         (clk),
        .rst_i       (rst_i),
        .dec_i       (dec),
        .exe_fw_i    (exe_fw),
        .wb_fw_i     (wb_fw),
        .rf_rdata1_i (rf_rdata1),
        .rf_rdata2_i (rf_rdata2),
        .exe_stall_i (exe_stall),
        .flush_i     (flush),
        .rf_raddr1_o (rf_raddr1),
        .rf_raddr2_o (rf_raddr2),
        .ds_stall_o  (ds_stall),
        .exec_o      (exec)
    );

    execute_stage #(
        .RESET_PC (RESET_PC)
    ) u_execute (
        .clk          (clk),
        .rst_i        (rst_i),
        .exec_i       (exec),
        .ds_stall_i   (ds_stall),
        .succ_pc_i    (succ_pc),
        .succ_valid_i (succ_valid),
        .exe_stall_o  (exe_stall),
        .flush_o      (flush),
        .redirect_o   (redirect_o),
        .exe_fw_o     (exe_fw),
        .wb_o         (wb)
    );

    writeback_regfile u_writeback (
        .clk         (clk),
        .rst_i       (rst_i),
        .wb_i        (wb),
        .rf_raddr1_i (rf_raddr1),
        .rf_raddr2_i (rf_raddr2),
        .rf_rdata1_o (rf_rdata1),
        .rf_rdata2_o (rf_rdata2),
        .wb_fw_o     (wb_fw),
        .retire_o    (retire_o)
    );

endmodule

`default_nettype wire

// File: bench/core_checker.sv
`default_nettype none
`timescale 1ns/1ps

module core_checker #(
    parameter int                 NROWS   = 1,
    parameter rv_isa_pkg::xword_t BASE_PC = 32'h0000_0000
) (
    input  wire                            clk,
    input  wire                            rst_i,
    input  wire                            fetch_ready_i,
    input  wire core_pipe_pkg::redirect_t  redirect_i,
    input  wire core_pipe_pkg::retire_t    retire_i,
    input  wire [NROWS-1:0]                row_retires_i,
    input  wire [NROWS-1:0]                row_wen_i,
    input  wire [NROWS-1:0][4:0]           row_rd_i,
    input  wire [NROWS-1:0][31:0]          row_value_i,
    output int                             value_errs_o,
    output int                             other_errs_o,
    output logic                           done_o
);

    int val_errs = 0;
    int oth_errs = 0;
    int idx = 0;
    int post_cnt = 0;

    assign value_errs_o = val_errs;
    assign other_errs_o = oth_errs;
    assign done_o       = !rst_i && idx >= NROWS;

    function automatic int next_row(input int from);
        int k;
        k = from + 1;
        while (k < NROWS && !row_retires_i[k]) begin
            k++;
        end
        return k;
    endfunction

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error %s: got %h, expected %h", name, got, exp);
            val_errs++;
        end
    endtask

    // the boot redirect lands in the second cycle after reset release
    task automatic verify_boot();
        if (fetch_ready_i || retire_i.valid) begin
            $display("fetch_ready_o or retire_o.valid went high before the first redirect");
            oth_errs++;
        end
        if (post_cnt == 0 && redirect_i.valid) begin
            $display("redirect_o pulsed in the cycle that reset was released");
            oth_errs++;
        end
        if (post_cnt == 1) begin
            if (!redirect_i.valid) begin
                $display("no redirect in the first cycle after reset");
                oth_errs++;
            end else begin
                compare_field("redirect_o.target", redirect_i.target, BASE_PC);
            end
        end
    endtask

    task automatic match_retire();
        int   nxt;
        logic jump;
        if (retire_i.valid) begin
            if (idx >= NROWS) begin
                $display("instruction at pc %h retired after the last program row", retire_i.pc);
                oth_errs++;
            end else begin
                compare_field("retire_o.pc", retire_i.pc, BASE_PC + 32'(idx * 4));
                compare_field("retire_o.rf_wen", 32'(retire_i.rf_wen), 32'(row_wen_i[idx]));
                if (row_wen_i[idx]) begin
                    compare_field("retire_o.rd", 32'(retire_i.rd), 32'(row_rd_i[idx]));
                    compare_field("retire_o.wdata", retire_i.wdata, row_value_i[idx]);
                end
                nxt  = next_row(idx);
                jump = (nxt < NROWS) && (nxt != idx + 1);
                // taken control flow always mispredicts against sequential fetch
                if (jump && !redirect_i.valid) begin
                    $display("taken control transfer at pc %h gave no redirect", retire_i.pc);
                    oth_errs++;
                end else if (jump) begin
                    compare_field("redirect_o.target", redirect_i.target,
                                  BASE_PC + 32'(nxt * 4));
                end else if (redirect_i.valid) begin
                    $display("unexpected redirect to %h after pc %h",
                             redirect_i.target, retire_i.pc);
                    oth_errs++;
                end
                idx = nxt;
            end
        end else if (redirect_i.valid) begin
            $display("redirect to %h without a retiring branch or jump", redirect_i.target);
            oth_errs++;
        end
    endtask

    always @(negedge clk) begin
        if (rst_i) begin
            idx      = next_row(-1);
            post_cnt = 0;
            if (fetch_ready_i || redirect_i.valid || retire_i.valid) begin
                $display("fetch_ready_o, redirect_o.valid or retire_o.valid high during reset");
                oth_errs++;
            end
        end else begin
            if (post_cnt < 2) begin
                verify_boot();
            end else begin
                match_retire();
            end
            post_cnt++;
        end
    end

endmodule

`default_nettype wire

// File: bench/core_tb.sv
`default_nettype none
`timescale 1ns/1ps

module core_tb;

    localparam rv_isa_pkg::xword_t RESET_PC        = 32'h0000_0100;
    localparam int                 NROWS           = 27;
    localparam int                 WATCHDOG_CYCLES = NROWS * 8 + 50;

    logic                        clk;
    logic                        rst_i;
    core_pipe_pkg::fetch_resp_t  fetch_resp;
    logic                        fetch_ready;
    core_pipe_pkg::redirect_t    redirect;
    core_pipe_pkg::retire_t      retire;
    int                          value_errs;
    int                          other_errs;
    logic                        done;
    integer                      seed = 32'h7d6;

    // program table with row n at RESET_PC + 4n
    logic [31:0]            prog_inst [NROWS];
    logic [NROWS-1:0]       row_retires;
    logic [NROWS-1:0]       row_wen;
    logic [NROWS-1:0][4:0]  row_rd;
    logic [NROWS-1:0][31:0] row_value;
    int                     row_count = 0;

    rv_core_top #(
        .RESET_PC (RESET_PC)
    ) dut (
        .clk           (clk),
        .rst_i         (rst_i),
        .fetch_resp_i  (fetch_resp),
        .fetch_ready_o (fetch_ready),
        .redirect_o    (redirect),
        .retire_o      (retire)
    );

    core_checker #(
        .NROWS   (NROWS),
        .BASE_PC (RESET_PC)
    ) u_checker (
        .clk           (clk),
        .rst_i         (rst_i),
        .fetch_ready_i (fetch_ready),
        .redirect_i    (redirect),
        .retire_i      (retire),
        .row_retires_i (row_retires),
        .row_wen_i     (row_wen),
        .row_rd_i      (row_rd),
        .row_value_i   (row_value),
        .value_errs_o  (value_errs),
        .other_errs_o  (other_errs),
        .done_o        (done)
    );

    task automatic add_row(input logic [31:0] inst, input logic retires, input logic wen,
                           input logic [4:0] rd, input logic [31:0] value);
        prog_inst[row_count]   = inst;
        row_retires[row_count] = retires;
        row_wen[row_count]     = wen;
        row_rd[row_count]      = rd;
        row_value[row_count]   = value;
        row_count++;
    endtask

    function automatic logic in_program(input logic [31:0] pc);
        return pc >= RESET_PC && pc < RESET_PC + 32'(NROWS * 4);
    endfunction

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // fetch source runs sequentially from the last redirect target
    initial begin
        logic [31:0] pc;
        logic [31:0] redir_pc;
        logic        took;
        logic        redir;
        logic        started;
        pc         = RESET_PC;
        started    = 1'b0;
        fetch_resp = '0;
        forever begin
            @(negedge clk);
            took     = fetch_resp.valid && fetch_ready;
            redir    = redirect.valid;
            redir_pc = redirect.target;
            @(posedge clk);
            #1;
            if (redir) begin
                pc      = redir_pc;
                started = 1'b1;
            end else if (took) begin
                pc = pc + 32'd4;
            end
            // a held item stays until taken
            if (redir || took || !fetch_resp.valid) begin
                fetch_resp.valid = started && in_program(pc) && (($random(seed) & 3) != 0);
                fetch_resp.pc    = pc;
                fetch_resp.inst  = in_program(pc) ? prog_inst[(pc - RESET_PC) >> 2]
                                                  : rv_isa_pkg::INST_NOP;
            end
        end
    end

    initial begin
        rst_i = 1'b1;
        // alu register ops on x1 = 5 and x2 = -3
        add_row(32'h00500093, 1'b1, 1'b1, 5'd1,  32'h0000_0005);
        add_row(32'hFFD00113, 1'b1, 1'b1, 5'd2,  32'hFFFF_FFFD);
        add_row(32'h002081B3, 1'b1, 1'b1, 5'd3,  32'h0000_0002);
        add_row(32'h40118233, 1'b1, 1'b1, 5'd4,  32'hFFFF_FFFD);
        add_row(32'h0020F2B3, 1'b1, 1'b1, 5'd5,  32'h0000_0005);
        add_row(32'h0020E333, 1'b1, 1'b1, 5'd6,  32'hFFFF_FFFD);
        add_row(32'h0020C3B3, 1'b1, 1'b1, 5'd7,  32'hFFFF_FFF8);
        add_row(32'h00112433, 1'b1, 1'b1, 5'd8,  32'h0000_0001);
        // lui and immediate chain
        add_row(32'h123454B7, 1'b1, 1'b1, 5'd9,  32'h1234_5000);
        add_row(32'h6784E513, 1'b1, 1'b1, 5'd10, 32'h1234_5678);
        add_row(32'hFFF54593, 1'b1, 1'b1, 5'd11, 32'hEDCB_A987);
        add_row(32'h0FF5F613, 1'b1, 1'b1, 5'd12, 32'h0000_0087);
        add_row(32'hFFC12693, 1'b1, 1'b1, 5'd13, 32'h0000_0000);
        // beq taken to 0x140
        add_row(32'h00108663, 1'b1, 1'b0, 5'd0,  32'h0000_0000);
        add_row(32'h7FF00713, 1'b0, 1'b1, 5'd14, 32'h0000_07FF);
        add_row(32'h7FF00793, 1'b0, 1'b1, 5'd15, 32'h0000_07FF);
        // bne not taken, then blt taken to 0x150
        add_row(32'h00109463, 1'b1, 1'b0, 5'd0,  32'h0000_0000);
        add_row(32'h00114663, 1'b1, 1'b0, 5'd0,  32'h0000_0000);
        add_row(32'h00100713, 1'b0, 1'b1, 5'd14, 32'h0000_0001);
        add_row(32'h00200713, 1'b0, 1'b1, 5'd14, 32'h0000_0002);
        // bge not taken then jal x1 to 0x160
        add_row(32'h00115463, 1'b1, 1'b0, 5'd0,  32'h0000_0000);
        add_row(32'h00C000EF, 1'b1, 1'b1, 5'd1,  32'h0000_0158);
        add_row(32'h00300713, 1'b0, 1'b1, 5'd14, 32'h0000_0003);
        add_row(32'h00400713, 1'b0, 1'b1, 5'd14, 32'h0000_0004);
        add_row(32'h00408813, 1'b1, 1'b1, 5'd16, 32'h0000_015C);
        add_row(32'h010808B3, 1'b1, 1'b1, 5'd17, 32'h0000_02B8);
        add_row(32'h40388933, 1'b1, 1'b1, 5'd18, 32'h0000_02B6);
        repeat (10) @(posedge clk);
        #1;
        rst_i = 1'b0;
        wait (done);
        // catch stray retires past the end
        repeat (10) @(posedge clk);
        #1;
        $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        wait (!rst_i);
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: program did not retire within %0d cycles after reset",
                 WATCHDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
hw/rv_isa_pkg.sv
hw/core_pipe_pkg.sv
hw/inst_decode.sv
hw/operand_stage.sv
hw/execute_stage.sv
hw/writeback_regfile.sv
hw/rv_core_top.sv
bench/core_checker.sv
bench/core_tb.sv
